/* list.f */
+incdir+design
design/sys_bus_pkg.sv
design/sys_addr_pkg.sv
design/addr_decode.sv
design/l2_banks.sv
design/ctrl_registers.sv
design/bootrom.sv
design/resp_mux.sv
design/mem_system.sv
test/tb_mem_system.sv

/* Bender.yml */
package:
  name: mem_system

sources:
  - include_dirs:
      - design
    files:
      - design/sys_bus_pkg.sv
      - design/sys_addr_pkg.sv
      - design/addr_decode.sv
      - design/l2_banks.sv
      - design/ctrl_registers.sv
      - design/bootrom.sv
      - design/resp_mux.sv
      - design/mem_system.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_mem_system.sv

/* test/tb_mem_system.sv */
/*
 * Testbench for the memory system: L2 traffic, boot ROM, unmapped and
 * control register accesses checked against a reference model
 */
`timescale 1ns/1ps

module tb_mem_system;

  `include "bootrom_image.svh"

  // Expected response plus the side outputs that go with it
  typedef struct packed {
    sys_bus_pkg::mem_rsp_t             rsp;
    logic [sys_addr_pkg::NumCores-1:0] wake;
    logic                              eoc;
  } expect_t;

  localparam int unsigned NumTestAddrs  = 16;
  localparam int unsigned PartialWrites = 24;
  localparam int unsigned RawPairs      = 8;
  // L2, then ROM, unmapped, control and wake-up requests
  localparam int unsigned TotalRequests = 2 * NumTestAddrs + PartialWrites + 2 * RawPairs +
                                          20 + 5 + 8 + 4;
  localparam int unsigned CycleLimit    = 2 * TotalRequests + 50;

  logic                              clk_i;
  logic                              rst_n_i;
  logic                              req_i;
  sys_bus_pkg::mem_req_t             req_data_i;
  logic                              rsp_valid_o;
  sys_bus_pkg::mem_rsp_t             rsp_o;
  logic                              eoc_valid_o;
  logic [sys_addr_pkg::NumCores-1:0] wake_up_o;

  sys_bus_pkg::data_t l2_model [sys_addr_pkg::L2Size / 4];
  sys_bus_pkg::data_t eoc_model;
  expect_t            exp_q [$];
  sys_bus_pkg::addr_t addr_list [NumTestAddrs];
  integer             seed;
  int unsigned        cycles;

  mem_system mem_system_i (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_i       (req_i      ),
    .req_data_i  (req_data_i ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o      ),
    .eoc_valid_o (eoc_valid_o),
    .wake_up_o   (wake_up_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Reference model of the address map, L2 contents and registers
  function automatic expect_t predict_response(input sys_bus_pkg::mem_req_t req);
    expect_t            res;
    sys_bus_pkg::addr_t off;
    res = '0;
    if (req.addr >= sys_addr_pkg::L2BaseAddr &&
        req.addr < sys_addr_pkg::L2BaseAddr + sys_addr_pkg::L2Size) begin
      off = (req.addr - sys_addr_pkg::L2BaseAddr) >> 2;
      if (req.we) begin
        for (int b = 0; b < sys_bus_pkg::StrbWidth; b++) begin
          if (req.strb[b]) l2_model[off][b*8 +: 8] = req.wdata[b*8 +: 8];
        end
      end else begin
        res.rsp.rdata = l2_model[off];
      end
    end else if (req.addr >= sys_addr_pkg::RomBaseAddr &&
                 req.addr <= sys_addr_pkg::RomEndAddr) begin
      off = (req.addr - sys_addr_pkg::RomBaseAddr) >> 2;
      if (req.we) res.rsp.err = 1'b1;
      else if (off < sys_addr_pkg::RomWords) res.rsp.rdata = RomImage[off];
    end else if (req.addr >= sys_addr_pkg::CtrlBaseAddr &&
                 req.addr < sys_addr_pkg::CtrlEndAddr) begin
      off = req.addr - sys_addr_pkg::CtrlBaseAddr;
      if (req.we && off == sys_addr_pkg::EocOffset) begin
        eoc_model = req.wdata;
      end else if (req.we && off == sys_addr_pkg::WakeUpOffset) begin
        if (req.wdata == sys_addr_pkg::WakeAll) res.wake = '1;
        else if (req.wdata < sys_addr_pkg::NumCores) res.wake[req.wdata] = 1'b1;
      end else if (!req.we) begin
        case (off)
          sys_addr_pkg::EocOffset:       res.rsp.rdata = eoc_model;
          sys_addr_pkg::TcdmStartOffset: res.rsp.rdata = sys_addr_pkg::TcdmBaseAddr;
          sys_addr_pkg::TcdmEndOffset:   res.rsp.rdata = 32'h0001_0000;
          sys_addr_pkg::NrCoresOffset:   res.rsp.rdata = 32'd8;
          default:                       res.rsp.rdata = '0;
        endcase
      end
    end else begin
      res.rsp.err = 1'b1;
    end
    res.eoc = eoc_model[0];
    return res;
  endfunction

  task automatic issue_request(input logic we, input sys_bus_pkg::addr_t addr,
                               input sys_bus_pkg::data_t wdata, input sys_bus_pkg::strb_t strb);
    sys_bus_pkg::mem_req_t req;
    req = '{we: we, addr: addr, wdata: wdata, strb: strb};
    @(posedge clk_i);
    #1;
    req_i      = 1'b1;
    req_data_i = req;
    exp_q.push_back(predict_response(req));
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      req_i      = 1'b0;
      req_data_i = '0;
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    report_failure($sformatf("Timeout after %0d cycles, %0d responses still outstanding",
                             cycles, exp_q.size()));
  end

  // Response check in the cycle after each request
  initial begin : compare_responses
    expect_t                           exp;
    logic                              pending;
    logic                              active;
    logic                              eoc_exp;
    logic [sys_addr_pkg::NumCores-1:0] wake_exp;
    eoc_exp = 1'b0;
    forever begin
      @(posedge clk_i);
      pending = req_i;
      active  = rst_n_i;
      @(negedge clk_i);
      wake_exp = '0;
      if (active) begin
        assert (rsp_valid_o === pending) else
          report_failure($sformatf("%s response at %0t", pending ? "Missing" : "Unexpected",
                                   $time));
        if (pending) begin
          exp      = exp_q.pop_front();
          wake_exp = exp.wake;
          eoc_exp  = exp.eoc;
          assert (rsp_o.err === exp.rsp.err) else
            report_failure($sformatf("Mismatch at %0t: rsp_o.err expected %b, got %b",
                                     $time, exp.rsp.err, rsp_o.err));
          assert (rsp_o.rdata === exp.rsp.rdata) else
            report_failure($sformatf("Mismatch at %0t: rsp_o.rdata expected %h, got %h",
                                     $time, exp.rsp.rdata, rsp_o.rdata));
        end
        assert (wake_up_o === wake_exp) else
          report_failure($sformatf("Mismatch at %0t: wake_up_o expected %b, got %b",
                                   $time, wake_exp, wake_up_o));
        assert (eoc_valid_o === eoc_exp) else
          report_failure($sformatf("Mismatch at %0t: eoc_valid_o expected %b, got %b",
                                   $time, eoc_exp, eoc_valid_o));
      end
    end
  end

  initial begin : drive_stimulus
    logic [31:0] rnd;
    seed       = 32'h2971;
    eoc_model  = '0;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // L2 full writes, partial overwrites, reads, then write-read pairs
    for (int i = 0; i < NumTestAddrs; i++) begin
      rnd          = $random(seed);
      addr_list[i] = sys_addr_pkg::L2BaseAddr + {rnd[9:0], 2'b00};
      issue_request(1'b1, addr_list[i], $random(seed), '1);
    end
    for (int i = 0; i < PartialWrites; i++) begin
      rnd = $random(seed);
      issue_request(1'b1, addr_list[rnd[3:0]], $random(seed), rnd[7:4]);
    end
    for (int i = 0; i < NumTestAddrs; i++) issue_request(1'b0, addr_list[i], '0, '0);
    for (int i = 0; i < RawPairs; i++) begin
      rnd = $random(seed);
      issue_request(1'b1, addr_list[rnd[3:0]], $random(seed), rnd[7:4]);
      issue_request(1'b0, addr_list[rnd[3:0]], '0, '0);
    end
    idle_cycles(2);

    // Boot ROM inside and above the image, a rejected write and a re-read
    for (int i = 0; i <= sys_addr_pkg::RomWords; i++) begin
      issue_request(1'b0, sys_addr_pkg::RomBaseAddr + 4 * i, '0, '0);
    end
    issue_request(1'b0, 32'hA000_FFFC, '0, '0);
    issue_request(1'b1, 32'hA000_0004, 32'h1234_5678, '1);
    issue_request(1'b0, 32'hA000_0004, '0, '0);
    idle_cycles(2);

    // Unmapped space, including the first address past each region
    issue_request(1'b0, 32'h1000_0000, '0, '0);
    issue_request(1'b1, 32'h1000_0000, 32'hCAFE_F00D, '1);
    issue_request(1'b0, 32'h8000_1000, '0, '0);
    issue_request(1'b0, 32'h4001_0000, '0, '0);
    issue_request(1'b0, 32'hA001_0000, '0, '0);
    idle_cycles(2);

    // EOC set with a single byte strobe and clear, then the read-only info registers
    issue_request(1'b1, 32'h4000_0000, 32'h5A00_00A5, 4'h1);
    issue_request(1'b0, 32'h4000_0000, '0, '0);
    issue_request(1'b1, 32'h4000_0000, 32'h0000_0F00, '1);
    issue_request(1'b0, 32'h4000_0000, '0, '0);
    issue_request(1'b0, 32'h4000_0008, '0, '0);
    issue_request(1'b0, 32'h4000_000C, '0, '0);
    issue_request(1'b0, 32'h4000_0010, '0, '0);
    issue_request(1'b0, 32'h4000_0014, '0, '0);
    idle_cycles(2);

    // Wake-up of one core, all cores and an out-of-range core
    issue_request(1'b1, 32'h4000_0004, 32'd3, '1);
    idle_cycles(1);
    issue_request(1'b1, 32'h4000_0004, 32'hFFFF_FFFF, '1);
    idle_cycles(1);
    issue_request(1'b1, 32'h4000_0004, 32'd9, '1);
    issue_request(1'b0, 32'h4000_0004, '0, '0);
    idle_cycles(1);

    while (exp_q.size() != 0) @(posedge clk_i);
    idle_cycles(2);
    $display("TEST OK");
    $finish;
  end

endmodule : tb_mem_system

/* design/mem_system.sv */
/*
 * Memory system top: host request port decoded onto L2, boot ROM and
 * control registers, with a single-cycle response path
 */
`timescale 1ns/1ps

module mem_system (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              req_i,
  input  sys_bus_pkg::mem_req_t             req_data_i,
  output logic                              rsp_valid_o,
  output sys_bus_pkg::mem_rsp_t             rsp_o,
  output logic                              eoc_valid_o,
  output logic [sys_addr_pkg::NumCores-1:0] wake_up_o
);

  logic                  l2_sel;
  logic                  rom_sel;
  logic                  ctrl_sel;
  sys_addr_pkg::region_e region;
  sys_bus_pkg::data_t    l2_rdata;
  sys_bus_pkg::data_t    rom_rdata;
  sys_bus_pkg::data_t    ctrl_rdata;

  addr_decode i_addr_decode (
    .req_i      (req_i     ),
    .req_data_i (req_data_i),
    .l2_sel_o   (l2_sel    ),
    .rom_sel_o  (rom_sel   ),
    .ctrl_sel_o (ctrl_sel  ),
    .region_o   (region    )
  );

  l2_banks i_l2_banks (
    .clk_i      (clk_i     ),
    .sel_i      (l2_sel    ),
    .req_data_i (req_data_i),
    .rdata_o    (l2_rdata  )
  );

  bootrom i_bootrom (
    .clk_i   (clk_i          ),
    .sel_i   (rom_sel        ),
    .addr_i  (req_data_i.addr),
    .rdata_o (rom_rdata      )
  );

  ctrl_registers i_ctrl_registers (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .sel_i       (ctrl_sel   ),
    .req_data_i  (req_data_i ),
    .rdata_o     (ctrl_rdata ),
    .eoc_valid_o (eoc_valid_o),
    .wake_up_o   (wake_up_o  )
  );

  resp_mux i_resp_mux (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .req_i        (req_i        ),
    .we_i         (req_data_i.we),
    .region_i     (region       ),
    .l2_rdata_i   (l2_rdata     ),
    .rom_rdata_i  (rom_rdata    ),
    .ctrl_rdata_i (ctrl_rdata   ),
    .rsp_valid_o  (rsp_valid_o  ),
    .rsp_o        (rsp_o        )
  );

endmodule : mem_system

/* design/resp_mux.sv */
/*
 * Response path: delays valid and region by one cycle and returns the
 * matching read word or an error
 */
`timescale 1ns/1ps

module resp_mux (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  sys_addr_pkg::region_e region_i,
  input  sys_bus_pkg::data_t    l2_rdata_i,
  input  sys_bus_pkg::data_t    rom_rdata_i,
  input  sys_bus_pkg::data_t    ctrl_rdata_i,
  output logic                  rsp_valid_o,
  output sys_bus_pkg::mem_rsp_t rsp_o
);

  logic                  valid_q;
  logic                  we_q;
  sys_addr_pkg::region_e region_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= sys_addr_pkg::RegionNone;
    end else begin
      valid_q <= req_i;
      if (req_i) begin
        we_q     <= we_i;
        region_q <= region_i;
      end
    end
  end

  always_comb begin
    rsp_o.err   = (region_q == sys_addr_pkg::RegionNone);
    rsp_o.rdata = '0;
    // Writes and errors return a zero word
    if (!we_q) begin
      case (region_q)
        sys_addr_pkg::RegionL2:   rsp_o.rdata = l2_rdata_i;
        sys_addr_pkg::RegionRom:  rsp_o.rdata = rom_rdata_i;
        sys_addr_pkg::RegionCtrl: rsp_o.rdata = ctrl_rdata_i;
        default:                  rsp_o.rdata = '0;
      endcase
    end
  end

  assign rsp_valid_o = valid_q;

endmodule : resp_mux

/* design/bootrom.sv */
/*
 * Boot ROM: constant boot image behind a registered read port
 */
`timescale 1ns/1ps

module bootrom (
  input  logic               clk_i,
  input  logic               sel_i,
  input  sys_bus_pkg::addr_t addr_i,
  output sys_bus_pkg::data_t rdata_o
);

  `include "bootrom_image.svh"

  sys_bus_pkg::addr_t                          word_off;
  logic [$clog2(sys_addr_pkg::RomWords)-1:0] rom_idx;

  // Word offset into the ROM window, table index from bits [5:2]
  assign word_off = (addr_i - sys_addr_pkg::RomBaseAddr) >> 2;
  assign rom_idx  = addr_i[$clog2(sys_addr_pkg::RomWords)+1:2];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= (word_off < sys_addr_pkg::RomWords) ? RomImage[rom_idx] : '0;
    end
  end

endmodule : bootrom

/* design/ctrl_registers.sv */
/*
 * Control registers: end-of-computation word, core wake-up trigger and
 * read-only TCDM range and core count
 */
`timescale 1ns/1ps

module ctrl_registers (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                sel_i,
  input  sys_bus_pkg::mem_req_t               req_data_i,
  output sys_bus_pkg::data_t                  rdata_o,
  output logic                                eoc_valid_o,
  output logic [sys_addr_pkg::NumCores-1:0]   wake_up_o
);

  sys_bus_pkg::addr_t                offset;
  logic                              wr_en;
  sys_bus_pkg::data_t                eoc_q;
  logic [sys_addr_pkg::NumCores-1:0] wake_up_d;
  logic [sys_addr_pkg::NumCores-1:0] wake_up_q;
  sys_bus_pkg::data_t                rdata_d;
  sys_bus_pkg::data_t                rdata_q;

  assign offset = req_data_i.addr - sys_addr_pkg::CtrlBaseAddr;
  assign wr_en  = sel_i && req_data_i.we;

  // Wake-up target, all cores, one core or none
  always_comb begin
    wake_up_d = '0;
    if (wr_en && (offset == sys_addr_pkg::WakeUpOffset)) begin
      if (req_data_i.wdata == sys_addr_pkg::WakeAll) begin
        wake_up_d = '1;
      end else if (req_data_i.wdata < sys_addr_pkg::NumCores) begin
        wake_up_d[req_data_i.wdata[$clog2(sys_addr_pkg::NumCores)-1:0]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
    end else begin
      wake_up_q <= wake_up_d;
      // Full word store, byte strobes do not apply here
      if (wr_en && (offset == sys_addr_pkg::EocOffset)) begin
        eoc_q <= req_data_i.wdata;
      end
    end
  end

  always_comb begin
    case (offset)
      sys_addr_pkg::EocOffset:       rdata_d = eoc_q;
      sys_addr_pkg::TcdmStartOffset: rdata_d = sys_addr_pkg::TcdmBaseAddr;
      sys_addr_pkg::TcdmEndOffset:   rdata_d = sys_addr_pkg::TcdmBaseAddr +
                                               sys_addr_pkg::TcdmSize;
      sys_addr_pkg::NrCoresOffset:   rdata_d = sys_bus_pkg::data_t'(sys_addr_pkg::NumCores);
      default:                       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && !req_data_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o     = rdata_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : ctrl_registers

/* design/l2_banks.sv */
/*
 * L2 SRAM: word-interleaved banks with byte-strobed writes and a
 * registered read port per bank
 */
`timescale 1ns/1ps

module l2_banks (
  input  logic                  clk_i,
  input  logic                  sel_i,
  input  sys_bus_pkg::mem_req_t req_data_i,
  output sys_bus_pkg::data_t    rdata_o
);

  logic [sys_addr_pkg::L2BankIdxWidth-1:0] bank_idx;
  logic [sys_addr_pkg::L2BankIdxWidth-1:0] bank_idx_q;
  logic [sys_addr_pkg::L2RowWidth-1:0]     row;
  logic [sys_addr_pkg::NumL2Banks-1:0]     bank_req;
  sys_bus_pkg::data_t                      bank_rdata_q [sys_addr_pkg::NumL2Banks];

  // Bank from address bits [3:2], row from the bits above
  assign bank_idx = req_data_i.addr[sys_addr_pkg::L2BankIdxWidth+1:2];
  assign row      = req_data_i.addr[sys_addr_pkg::L2RowWidth+sys_addr_pkg::L2BankIdxWidth+1:
                                    sys_addr_pkg::L2BankIdxWidth+2];

  for (genvar b = 0; b < sys_addr_pkg::NumL2Banks; b++) begin : gen_bank
    sys_bus_pkg::data_t mem_q [sys_addr_pkg::L2BankWords];

    assign bank_req[b] = sel_i && (bank_idx == sys_addr_pkg::L2BankIdxWidth'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req[b]) begin
        if (req_data_i.we) begin
          for (int unsigned i = 0; i < sys_bus_pkg::StrbWidth; i++) begin
            if (req_data_i.strb[i]) begin
              mem_q[row][i*8 +: 8] <= req_data_i.wdata[i*8 +: 8];
            end
          end
        end else begin
          bank_rdata_q[b] <= mem_q[row];
        end
      end
    end
  end

  // Remember which bank answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      bank_idx_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata_q[bank_idx_q];

endmodule : l2_banks

/* design/addr_decode.sv */
/*
 * Address decoder: maps each host request onto L2, boot ROM or control
 * registers and flags unmapped accesses and ROM writes as errors
 */
`timescale 1ns/1ps

module addr_decode (
  input  logic                  req_i,
  input  sys_bus_pkg::mem_req_t req_data_i,
  output logic                  l2_sel_o,
  output logic                  rom_sel_o,
  output logic                  ctrl_sel_o,
  output sys_addr_pkg::region_e region_o
);

  sys_bus_pkg::addr_t addr;
  logic               in_l2;
  logic               in_rom;
  logic               in_ctrl;

  assign addr = req_data_i.addr;

  // Range checks, ROM end is inclusive
  assign in_l2   = (addr >= sys_addr_pkg::L2BaseAddr) &&
                   (addr < sys_addr_pkg::L2BaseAddr + sys_addr_pkg::L2Size);
  assign in_rom  = (addr >= sys_addr_pkg::RomBaseAddr) &&
                   (addr <= sys_addr_pkg::RomEndAddr);
  assign in_ctrl = (addr >= sys_addr_pkg::CtrlBaseAddr) &&
                   (addr < sys_addr_pkg::CtrlEndAddr);

  always_comb begin
    region_o = sys_addr_pkg::RegionNone;
    if (in_l2) begin
      region_o = sys_addr_pkg::RegionL2;
    end else if (in_rom && !req_data_i.we) begin
      // ROM writes fall through to the error region
      region_o = sys_addr_pkg::RegionRom;
    end else if (in_ctrl) begin
      region_o = sys_addr_pkg::RegionCtrl;
    end
  end

  assign l2_sel_o   = req_i && (region_o == sys_addr_pkg::RegionL2);
  assign rom_sel_o  = req_i && (region_o == sys_addr_pkg::RegionRom);
  assign ctrl_sel_o = req_i && (region_o == sys_addr_pkg::RegionCtrl);

endmodule : addr_decode

/* design/sys_addr_pkg.sv */
/*
 * System address map: target regions, L2 bank geometry, boot ROM size
 * and the control register offsets with their read-only values
 */
package sys_addr_pkg;

  typedef enum logic [1:0] {
    RegionL2,
    RegionRom,
    RegionCtrl,
    RegionNone
  } region_e;

  // L2 SRAM, interleaved word by word across the banks
  localparam sys_bus_pkg::addr_t L2BaseAddr     = 32'h8000_0000;
  localparam int unsigned        L2Size         = 4096;
  localparam int unsigned        NumL2Banks     = 4;
  localparam int unsigned        L2BankWords    = 256;
  localparam int unsigned        L2BankIdxWidth = 2;
  localparam int unsigned        L2RowWidth     = 8;

  // Boot ROM, end address is inclusive
  localparam sys_bus_pkg::addr_t RomBaseAddr = 32'hA000_0000;
  localparam sys_bus_pkg::addr_t RomEndAddr  = 32'hA000_FFFF;
  localparam int unsigned        RomWords    = 16;

  // Control registers
  localparam sys_bus_pkg::addr_t CtrlBaseAddr = 32'h4000_0000;
  localparam sys_bus_pkg::addr_t CtrlEndAddr  = 32'h4001_0000;

  localparam sys_bus_pkg::addr_t EocOffset       = 32'h0000_0000;
  localparam sys_bus_pkg::addr_t WakeUpOffset    = 32'h0000_0004;
  localparam sys_bus_pkg::addr_t TcdmStartOffset = 32'h0000_0008;
  localparam sys_bus_pkg::addr_t TcdmEndOffset   = 32'h0000_000C;
  localparam sys_bus_pkg::addr_t NrCoresOffset   = 32'h0000_0010;

  // Values reported by the info registers
  localparam int unsigned        NumCores     = 8;
  localparam sys_bus_pkg::addr_t TcdmBaseAddr = 32'h0000_0000;
  localparam sys_bus_pkg::addr_t TcdmSize     = 32'h0001_0000;

  // Wake-up value that addresses every core at once
  localparam sys_bus_pkg::data_t WakeAll = 32'hFFFF_FFFF;

endpackage : sys_addr_pkg

/* design/sys_bus_pkg.sv */
/*
 * Memory bus types: data, strobe and address words plus the request and
 * response structs carried between the host port and the targets
 */
package sys_bus_pkg;

  // Word geometry
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [31:0]          addr_t;

  // One word-wide access from the host
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  // Read word and error flag, valid one cycle after the request
  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

endpackage : sys_bus_pkg

/* design/bootrom_image.svh */
/*
 * Boot image: each core reads its hart id, parks in wfi and jumps to L2 once woken
 */
localparam sys_bus_pkg::data_t RomImage [sys_addr_pkg::RomWords] = '{
  32'hF140_2573,
  32'h4000_02B7,
  32'h0002_8293,
  32'h1050_0073,
  32'h8000_0337,
  32'h0003_0313,
  32'h0003_0067,
  32'h0000_0013,
  32'h0000_0013,
  32'h0000_0013,
  32'h0000_0013,
  32'h0000_0013,
  32'hFF5F_F06F,
  32'h0000_006F,
  32'hDEAD_BEEF,
  32'h0B00_7C0D
};
